//--- Bender.yml
package:
  name: frontend

sources:
  - files:
      - logic/frontend_pkg.sv
      - logic/resolve_if.sv
      - logic/fetch_rsp_if.sv
      - logic/pc_gen.sv
      - logic/bht.sv
      - logic/branch_predict.sv
      - logic/fetch_queue.sv
      - logic/frontend_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/frontend_properties.sv
      - verification/tb_frontend.sv

//--- logic/bht.sv
//------------------------------
// branch history table
// valid bit and 2-bit counter per entry
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module bht (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire frontend_pkg::bht_idx_t lookup_idx_i,
    resolve_if.bht                      res,
    output logic                        known_o,
    output logic                        taken_o
);

    logic                   valid_q [frontend_pkg::BHT_ENTRIES];
    frontend_pkg::bht_cnt_t cnt_q   [frontend_pkg::BHT_ENTRIES];
    frontend_pkg::bht_idx_t upd_idx;
    logic                   upd_en;

    // combinational lookup for the word in the response cycle
    assign known_o = valid_q[lookup_idx_i];
    assign taken_o = cnt_q[lookup_idx_i][1];

    // train on resolved conditional branches only
    assign upd_en  = res.valid & res.is_branch;
    assign upd_idx = res.pc[frontend_pkg::BHT_IDX_W+1:2];

    // valid bits, all clear out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < frontend_pkg::BHT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    //------------------------------
    // counter update
    //------------------------------
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            if (!valid_q[upd_idx]) begin
                // first training lands on the weak state
                cnt_q[upd_idx] <= res.taken ? 2'd2 : 2'd1;
            end else if (res.taken && cnt_q[upd_idx] != 2'd3) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
            end else if (!res.taken && cnt_q[upd_idx] != 2'd0) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/branch_predict.sv
//------------------------------
// scan of the fetched word for branch and jal
// immediate decode, direction and target
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module branch_predict (
    fetch_rsp_if.predictor               rsp,
    output frontend_pkg::bht_idx_t       lookup_idx_o,
    input  wire logic                    known_i,
    input  wire logic                    taken_i
);

    frontend_pkg::instr_t instr;
    logic                 is_branch;
    logic                 is_jal;
    frontend_pkg::addr_t  imm_b;
    frontend_pkg::addr_t  imm_j;
    frontend_pkg::addr_t  imm;
    logic                 taken;

    assign instr = rsp.instr;

    // bht entry of this word
    assign lookup_idx_o = rsp.pc[frontend_pkg::BHT_IDX_W+1:2];

    // opcode decode
    assign is_branch = (instr[6:0] == frontend_pkg::OPC_BRANCH);
    assign is_jal    = (instr[6:0] == frontend_pkg::OPC_JAL);

    //------------------------------
    // immediates, sign extended
    //------------------------------
    // b-type imm[12:1]
    assign imm_b = {{(frontend_pkg::VLEN-13){instr[31]}},
                    instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    // j-type imm[20:1]
    assign imm_j = {{(frontend_pkg::VLEN-21){instr[31]}},
                    instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign imm = is_jal ? imm_j : imm_b;

    // direction
    always_comb begin
        taken = 1'b0;
        if (is_jal) begin
            taken = 1'b1;
        end else if (is_branch) begin
            // trained entry wins, otherwise backward taken
            taken = known_i ? taken_i : imm_b[frontend_pkg::VLEN-1];
        end
    end

    always_comb begin
        rsp.cf = frontend_pkg::NoCF;
        if (is_jal) begin
            rsp.cf = frontend_pkg::Jump;
        end else if (taken) begin
            rsp.cf = frontend_pkg::Branch;
        end
    end

    // both jal and b-type are pc relative
    assign rsp.target   = rsp.pc + imm;
    // only a live response may steer the fetch
    assign rsp.redirect = rsp.valid & taken;

endmodule

`default_nettype wire

//--- logic/fetch_queue.sv
//------------------------------
// fetch queue toward the back-end
// circular buffer with valid/ready pop
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  kill_i,
    input  wire logic                  fetch_ready_i,
    fetch_rsp_if.sink                  rsp,
    output logic                       space_o,
    output logic                       fetch_valid_o,
    output frontend_pkg::addr_t        fetch_pc_o,
    output frontend_pkg::instr_t       fetch_instr_o,
    output frontend_pkg::cf_t          fetch_cf_o,
    output frontend_pkg::addr_t        fetch_target_o
);

    // entry storage
    frontend_pkg::addr_t  pc_q     [frontend_pkg::QUEUE_DEPTH];
    frontend_pkg::instr_t instr_q  [frontend_pkg::QUEUE_DEPTH];
    frontend_pkg::cf_t    cf_q     [frontend_pkg::QUEUE_DEPTH];
    frontend_pkg::addr_t  target_q [frontend_pkg::QUEUE_DEPTH];

    frontend_pkg::queue_ptr_t wr_ptr_q, rd_ptr_q;
    frontend_pkg::queue_cnt_t count_q;
    // a request may be in flight, counted as if granted
    logic                     pending_q;
    logic                     push;
    logic                     pop;

    assign push = rsp.valid;
    assign pop  = fetch_valid_o & fetch_ready_i;

    // keep room for the word in flight plus a new one
    assign space_o = (count_q + frontend_pkg::queue_cnt_t'(pending_q))
                     < frontend_pkg::queue_cnt_t'(frontend_pkg::QUEUE_DEPTH);

    //------------------------------
    // pointers and fill count
    //------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else if (kill_i) begin
            // drop every entry and the word in flight
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            pending_q <= space_o;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + frontend_pkg::queue_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + frontend_pkg::queue_ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + frontend_pkg::queue_cnt_t'(1);
                2'b01:   count_q <= count_q - frontend_pkg::queue_cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // write into the tail slot
    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_q[wr_ptr_q]     <= rsp.pc;
            instr_q[wr_ptr_q]  <= rsp.instr;
            cf_q[wr_ptr_q]     <= rsp.cf;
            target_q[wr_ptr_q] <= rsp.target;
        end
    end

    // head entry to the back-end
    assign fetch_valid_o  = (count_q != '0);
    assign fetch_pc_o     = pc_q[rd_ptr_q];
    assign fetch_instr_o  = instr_q[rd_ptr_q];
    assign fetch_cf_o     = cf_q[rd_ptr_q];
    assign fetch_target_o = target_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- logic/fetch_rsp_if.sv
//------------------------------
// fetched word plus its prediction
// pc_gen -> branch_predict -> fetch_queue
//------------------------------
`timescale 1ns/1ps
`default_nettype none

interface fetch_rsp_if;

    // response of the memory port, valid in the response cycle
    logic                 valid;
    frontend_pkg::addr_t  pc;
    frontend_pkg::instr_t instr;
    // prediction for this word
    frontend_pkg::cf_t    cf;
    frontend_pkg::addr_t  target;
    logic                 redirect;

    // pc_gen owns valid and pc and takes the predicted redirect back
    modport source (output valid, output pc, input redirect, input target);

    // scanner looks at the word and produces the prediction
    modport predictor (input valid, input pc, input instr,
                       output cf, output target, output redirect);

    // queue stores the whole entry
    modport sink (input valid, input pc, input instr, input cf, input target);

endinterface

`default_nettype wire

//--- logic/frontend_pkg.sv
//------------------------------
// shared widths, types and sizes of the fetch frontend
// control flow kinds, bht and queue sizing, rv32i opcodes
//------------------------------
`default_nettype none

package frontend_pkg;

    // address and instruction words
    localparam int unsigned VLEN = 32;
    typedef logic [VLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;

    // kind of control flow predicted for one fetch entry
    typedef enum logic [1:0] {
        NoCF,
        Branch,
        Jump
    } cf_t;

    // branch history table, indexed by pc[5:2]
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = 4;
    typedef logic [BHT_IDX_W-1:0] bht_idx_t;
    // 2-bit saturating counter, msb is the taken prediction
    typedef logic [1:0] bht_cnt_t;

    // fetch queue toward the back-end
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;
    typedef logic [QUEUE_PTR_W-1:0]           queue_ptr_t;

    // rv32i major opcodes that the scanner looks for
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

`default_nettype wire

//--- logic/frontend_top.sv
//------------------------------
// fetch frontend top level
// pc_gen, bht, branch_predict, fetch_queue
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,
    input  wire frontend_pkg::addr_t  boot_addr_i,
    // instruction memory
    output logic                      imem_req_o,
    output frontend_pkg::addr_t       imem_addr_o,
    input  wire logic                 imem_gnt_i,
    input  wire frontend_pkg::instr_t imem_rdata_i,
    // branch resolution
    input  wire logic                 resolve_valid_i,
    input  wire frontend_pkg::addr_t  resolve_pc_i,
    input  wire frontend_pkg::addr_t  resolve_target_i,
    input  wire logic                 resolve_taken_i,
    input  wire logic                 resolve_mispredict_i,
    input  wire logic                 resolve_branch_i,
    // csr redirects
    input  wire logic                 eret_i,
    input  wire frontend_pkg::addr_t  epc_i,
    input  wire logic                 ex_valid_i,
    input  wire frontend_pkg::addr_t  trap_vector_i,
    // fetch entries to the back-end
    output logic                      fetch_valid_o,
    input  wire logic                 fetch_ready_i,
    output frontend_pkg::addr_t       fetch_pc_o,
    output frontend_pkg::instr_t      fetch_instr_o,
    output frontend_pkg::cf_t         fetch_cf_o,
    output frontend_pkg::addr_t       fetch_target_o
);

    resolve_if   res_if ();
    fetch_rsp_if rsp_if ();

    frontend_pkg::bht_idx_t lookup_idx;
    logic                   bht_known;
    logic                   bht_taken;
    logic                   kill;
    logic                   queue_space;

    // resolution strobe straight from the ports
    assign res_if.valid      = resolve_valid_i;
    assign res_if.pc         = resolve_pc_i;
    assign res_if.target     = resolve_target_i;
    assign res_if.taken      = resolve_taken_i;
    assign res_if.mispredict = resolve_mispredict_i;
    assign res_if.is_branch  = resolve_branch_i;

    // read data belongs to the response cycle
    assign rsp_if.instr = imem_rdata_i;

    pc_gen i_pc_gen (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .eret_i        ( eret_i        ),
        .epc_i         ( epc_i         ),
        .ex_valid_i    ( ex_valid_i    ),
        .trap_vector_i ( trap_vector_i ),
        .flush_i       ( flush_i       ),
        .imem_gnt_i    ( imem_gnt_i    ),
        .queue_space_i ( queue_space   ),
        .res           ( res_if        ),
        .rsp           ( rsp_if        ),
        .imem_req_o    ( imem_req_o    ),
        .imem_addr_o   ( imem_addr_o   ),
        .kill_o        ( kill          )
    );

    bht i_bht (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .lookup_idx_i ( lookup_idx ),
        .res          ( res_if     ),
        .known_o      ( bht_known  ),
        .taken_o      ( bht_taken  )
    );

    branch_predict i_branch_predict (
        .rsp          ( rsp_if     ),
        .lookup_idx_o ( lookup_idx ),
        .known_i      ( bht_known  ),
        .taken_i      ( bht_taken  )
    );

    fetch_queue i_fetch_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .kill_i         ( kill           ),
        .fetch_ready_i  ( fetch_ready_i  ),
        .rsp            ( rsp_if         ),
        .space_o        ( queue_space    ),
        .fetch_valid_o  ( fetch_valid_o  ),
        .fetch_pc_o     ( fetch_pc_o     ),
        .fetch_instr_o  ( fetch_instr_o  ),
        .fetch_cf_o     ( fetch_cf_o     ),
        .fetch_target_o ( fetch_target_o )
    );

endmodule

`default_nettype wire

//--- logic/pc_gen.sv
//------------------------------
// next pc register and priority select
// memory request gate, in-flight tracking, kill
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire frontend_pkg::addr_t boot_addr_i,
    input  wire logic                eret_i,
    input  wire frontend_pkg::addr_t epc_i,
    input  wire logic                ex_valid_i,
    input  wire frontend_pkg::addr_t trap_vector_i,
    input  wire logic                flush_i,
    input  wire logic                imem_gnt_i,
    input  wire logic                queue_space_i,
    resolve_if.pc_gen                res,
    fetch_rsp_if.source              rsp,
    output logic                     imem_req_o,
    output frontend_pkg::addr_t      imem_addr_o,
    output logic                     kill_o
);

    // set in reset, boot address goes into npc on the first edge
    logic                load_boot_q;
    frontend_pkg::addr_t npc_d, npc_q;
    // accepted request waiting for its word
    logic                pend_q;
    frontend_pkg::addr_t pend_addr_q;
    logic                mispredict;
    logic                accept;

    assign mispredict = res.valid & res.mispredict;
    // any back-end redirect throws away what is in flight
    assign kill_o     = mispredict | eret_i | ex_valid_i | flush_i;

    // predicted target is fetched right away in the response cycle
    assign imem_addr_o = rsp.redirect ? rsp.target : npc_q;
    // no request in a kill cycle, the redirected fetch goes next cycle
    assign imem_req_o  = queue_space_i & ~kill_o & ~load_boot_q;
    assign accept      = imem_req_o & imem_gnt_i;

    //------------------------------
    // next pc in rising priority
    //------------------------------
    always_comb begin
        npc_d = npc_q;
        if (load_boot_q) begin
            npc_d = boot_addr_i;
        end
        // target is kept if the fetch was not accepted
        if (rsp.redirect) begin
            npc_d = rsp.target;
        end
        // step past the address fetched in this cycle
        if (accept) begin
            npc_d = imem_addr_o + frontend_pkg::addr_t'(4);
        end
        if (mispredict) begin
            npc_d = res.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_boot_q <= 1'b1;
            npc_q       <= '0;
            pend_q      <= 1'b0;
        end else begin
            load_boot_q <= 1'b0;
            npc_q       <= npc_d;
            pend_q      <= accept;
        end
    end

    // address of the accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pend_addr_q <= imem_addr_o;
        end
    end

    // word arrives one cycle after acceptance, dropped on kill
    assign rsp.valid = pend_q & ~kill_o;
    assign rsp.pc    = pend_addr_q;

endmodule

`default_nettype wire

//--- logic/resolve_if.sv
//------------------------------
// branch resolution from the back-end
// one-cycle strobe into pc_gen and bht
//------------------------------
`timescale 1ns/1ps
`default_nettype none

interface resolve_if;

    // resolution strobe and its payload
    logic                valid;
    frontend_pkg::addr_t pc;
    frontend_pkg::addr_t target;
    logic                taken;
    logic                mispredict;
    logic                is_branch;

    // pc_gen only needs the redirect part
    modport pc_gen (input valid, input mispredict, input target);

    // bht trains on conditional branches
    modport bht (input valid, input pc, input taken, input is_branch);

endinterface

`default_nettype wire

//--- sources.f
logic/frontend_pkg.sv
logic/resolve_if.sv
logic/fetch_rsp_if.sv
logic/pc_gen.sv
logic/bht.sv
logic/branch_predict.sv
logic/fetch_queue.sv
logic/frontend_top.sv
verification/tb_clock_gen.sv
verification/frontend_properties.sv
verification/tb_frontend.sv

//--- verification/frontend_properties.sv
//------------------------------
// concurrent checks on the fetch queue
// reset output, stall stability, fill bound
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module frontend_properties (
    input wire logic                     clk_i,
    input wire logic                     rst_ni,
    input wire logic                     kill_i,
    input wire logic                     fetch_ready_i,
    input wire logic                     fetch_valid_o,
    input wire frontend_pkg::addr_t      fetch_pc_o,
    input wire frontend_pkg::instr_t     fetch_instr_o,
    input wire frontend_pkg::cf_t        fetch_cf_o,
    input wire frontend_pkg::addr_t      fetch_target_o,
    input wire frontend_pkg::queue_cnt_t count_q
);

    // number of failed checks so far
    int fail_count = 0;

    // queue must look empty while reset is held
    no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !fetch_valid_o)
        else begin
            $error("fetch_valid_o high during reset");
            fail_count++;
        end

    // stalled head entry stays put unless a kill empties the queue
    head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_o && !fetch_ready_i && !kill_i |=>
            fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o)
            && $stable(fetch_cf_o) && $stable(fetch_target_o))
        else begin
            $error("head entry changed while stalled");
            fail_count++;
        end

    count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= frontend_pkg::queue_cnt_t'(frontend_pkg::QUEUE_DEPTH))
        else begin
            $error("fill count above queue depth");
            fail_count++;
        end

endmodule

bind fetch_queue frontend_properties i_props (.*);

`default_nettype wire

//--- verification/tb_clock_gen.sv
//------------------------------
// testbench clock, 10 ns period
// active low reset held for 2 cycles
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        // release a little after the second rising edge
        repeat (2) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- verification/tb_frontend.sv
//------------------------------
// testbench of the fetch frontend
// memory model, redirect stimulus, reference model
// compare process and cycle timeout
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

    localparam frontend_pkg::addr_t BOOT = 32'h8000_0000;
    // about 80 pops with ready low half the time, plenty of margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk, rst_n;
    logic flush, imem_gnt, imem_req, res_valid, res_taken, res_misp, res_branch;
    logic eret, ex_valid, fetch_ready, fetch_valid;
    frontend_pkg::addr_t  boot_addr, imem_addr, res_pc, res_target, epc, trap_vector;
    frontend_pkg::addr_t  fetch_pc, fetch_target;
    frontend_pkg::instr_t imem_rdata, fetch_instr;
    frontend_pkg::cf_t    fetch_cf;

    integer seed = 60896;
    integer run_left = 0;
    int     mismatches = 0;
    int     other_errors = 0;
    int     pop_count = 0;
    int     cycles = 0;
    frontend_pkg::instr_t prog [64];
    // own copy of the bht
    logic [15:0] bv;
    logic [31:0] bc;
    frontend_pkg::addr_t exp_pc;
    logic                acc_s;
    frontend_pkg::addr_t acc_addr;

    tb_clock_gen i_clk (.clk_o(clk), .rst_no(rst_n));

    frontend_top dut (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .boot_addr_i(boot_addr),
        .imem_req_o(imem_req), .imem_addr_o(imem_addr), .imem_gnt_i(imem_gnt),
        .imem_rdata_i(imem_rdata), .resolve_valid_i(res_valid), .resolve_pc_i(res_pc),
        .resolve_target_i(res_target), .resolve_taken_i(res_taken),
        .resolve_mispredict_i(res_misp), .resolve_branch_i(res_branch),
        .eret_i(eret), .epc_i(epc), .ex_valid_i(ex_valid), .trap_vector_i(trap_vector),
        .fetch_valid_o(fetch_valid), .fetch_ready_i(fetch_ready), .fetch_pc_o(fetch_pc),
        .fetch_instr_o(fetch_instr), .fetch_cf_o(fetch_cf), .fetch_target_o(fetch_target)
    );

    //------------------------------
    // program image
    //------------------------------
    function automatic frontend_pkg::instr_t fill_word(frontend_pkg::addr_t a);
        // addi with fields from every address bit
        return {a[31:7] ^ a[24:0], 7'h13};
    endfunction

    function automatic frontend_pkg::instr_t enc_jal(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic frontend_pkg::instr_t enc_beq(logic [12:0] off);
        return {off[12], off[10:5], 10'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic frontend_pkg::instr_t mem_word(frontend_pkg::addr_t a);
        if (a >= BOOT && a < BOOT + 256) begin
            return prog[(a - BOOT) >> 2];
        end
        return fill_word(a);
    endfunction

    // expected follow-on pc, cf and target from the rv32i rules
    function automatic void next_pc(input frontend_pkg::addr_t pc,
                                    input frontend_pkg::instr_t w,
                                    input logic [15:0] v, input logic [31:0] c,
                                    output frontend_pkg::addr_t npc,
                                    output frontend_pkg::cf_t cf,
                                    output frontend_pkg::addr_t tgt);
        frontend_pkg::addr_t ib;
        frontend_pkg::addr_t ij;
        logic [3:0]          idx;
        logic                tk;
        ib  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        ij  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        idx = pc[5:2];
        npc = pc + 4;
        cf  = frontend_pkg::NoCF;
        tgt = '0;
        if (w[6:0] == 7'b1101111) begin
            cf  = frontend_pkg::Jump;
            tgt = pc + ij;
            npc = tgt;
        end else if (w[6:0] == 7'b1100011) begin
            // never trained: backward taken
            tk  = v[idx] ? c[2*idx+1] : ib[31];
            tgt = pc + ib;
            if (tk) begin
                cf  = frontend_pkg::Branch;
                npc = tgt;
            end
        end
    endfunction

    task automatic check_addr(string name, frontend_pkg::addr_t e, frontend_pkg::addr_t a);
        if (e !== a) begin
            $display("mismatch %s: expected %h, got %h", name, e, a);
            mismatches++;
        end
    endtask

    task automatic check_instr(string name, frontend_pkg::instr_t e,
                               frontend_pkg::instr_t a);
        if (e !== a) begin
            $display("mismatch %s: expected %h, got %h", name, e, a);
            mismatches++;
        end
    endtask

    task automatic check_cf(string name, frontend_pkg::cf_t e, frontend_pkg::cf_t a);
        if (e !== a) begin
            $display("mismatch %s: expected %h, got %h", name, e, a);
            mismatches++;
        end
    endtask

    //------------------------------
    // memory model and ready pattern
    //------------------------------
    always @(negedge clk) begin
        acc_s    = imem_req & imem_gnt;
        acc_addr = imem_addr;
        // no memory request while reset is held
        if (!rst_n && imem_req !== 1'b0) begin
            $display("imem_req_o was high while reset was held");
            other_errors++;
        end
    end

    always @(posedge clk) begin
        #1;
        imem_rdata = acc_s ? mem_word(acc_addr) : '0;
        imem_gnt   = ($random(seed) & 3) != 0;
        // long runs of one ready level
        if (run_left == 0) begin
            fetch_ready = $random(seed) & 1;
            run_left    = ($random(seed) & 15) + 1;
        end
        run_left = run_left - 1;
    end

    // compare process, sampled mid cycle
    always @(negedge clk) begin
        frontend_pkg::addr_t npc;
        frontend_pkg::addr_t tgt;
        frontend_pkg::cf_t   cf;
        logic [3:0]          i;
        if (rst_n) begin
            if (fetch_valid && fetch_ready) begin
                next_pc(exp_pc, mem_word(exp_pc), bv, bc, npc, cf, tgt);
                check_addr("fetch_pc_o", exp_pc, fetch_pc);
                check_instr("fetch_instr_o", mem_word(exp_pc), fetch_instr);
                check_cf("fetch_cf_o", cf, fetch_cf);
                if (cf != frontend_pkg::NoCF) begin
                    check_addr("fetch_target_o", tgt, fetch_target);
                end
                exp_pc = npc;
                pop_count++;
            end
            // redirect priority, trap highest
            if (ex_valid) begin
                exp_pc = trap_vector;
            end else if (eret) begin
                exp_pc = epc;
            end else if (res_valid && res_misp) begin
                exp_pc = res_target;
            end
            if (res_valid && res_branch) begin
                i = res_pc[5:2];
                if (!bv[i]) begin
                    bc[2*i+:2] = res_taken ? 2'd2 : 2'd1;
                end else if (res_taken && bc[2*i+:2] != 2'd3) begin
                    bc[2*i+:2] = bc[2*i+:2] + 2'd1;
                end else if (!res_taken && bc[2*i+:2] != 2'd0) begin
                    bc[2*i+:2] = bc[2*i+:2] - 2'd1;
                end
                bv[i] = 1'b1;
            end
        end
    end

    task automatic wait_pops(int n);
        int target;
        target = pop_count + n;
        while (pop_count < target) @(negedge clk);
    endtask

    // one-cycle strobe, issued while the queue holds entries
    task automatic strobe(logic mp, logic br, logic er, logic ex, logic fl,
                          frontend_pkg::addr_t a);
        @(posedge clk);
        #1;
        while (!fetch_valid) begin
            @(posedge clk);
            #1;
        end
        res_valid  = mp | br;
        res_misp   = mp;
        res_branch = br;
        res_taken  = br;
        res_pc     = a;
        res_target = a;
        eret       = er;
        ex_valid   = ex;
        flush      = fl;
        @(posedge clk);
        #1;
        {res_valid, res_misp, res_branch, res_taken, eret, ex_valid, flush} = '0;
    endtask

    // timeout watchdog
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    //------------------------------
    // stimulus
    //------------------------------
    initial begin
        {flush, imem_gnt, res_valid, res_taken, res_misp, res_branch} = '0;
        {eret, ex_valid, fetch_ready} = '0;
        boot_addr   = BOOT;
        res_pc      = '0;
        res_target  = '0;
        imem_rdata  = '0;
        epc         = BOOT + 32;
        trap_vector = BOOT + 160;
        bv          = '0;
        bc          = '0;
        exp_pc      = BOOT;
        for (int k = 0; k < 64; k++) begin
            prog[k] = fill_word(BOOT + 4 * k);
        end
        prog[4]  = enc_jal(21'd16);
        prog[8]  = enc_beq(13'd12);
        prog[10] = enc_beq(-13'sd8);
        prog[11] = enc_jal(-21'sd12);
        prog[33] = enc_beq(-13'sd4);
        prog[41] = enc_jal(-21'sd4);
        @(posedge rst_n);
        // boot, jal, forward and backward untrained branches
        wait_pops(20);
        strobe(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, BOOT + 128);
        wait_pops(10);
        // train the forward branch twice, outside the running loop
        strobe(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, BOOT + 32);
        strobe(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, BOOT + 32);
        wait_pops(6);
        strobe(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, BOOT + 128);
        wait_pops(12);
        strobe(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, BOOT + 128);
        wait_pops(8);
        // coinciding strobes, eret over mispredict then trap over all
        strobe(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, BOOT + 128);
        wait_pops(8);
        strobe(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, BOOT + 128);
        wait_pops(10);
        if (pop_count == 0) begin
            $display("no entry was ever popped");
            other_errors++;
        end
        // failures of the bound queue checks
        other_errors += dut.i_fetch_queue.i_props.fail_count;
        $display("errors: %0d mismatches, %0d other, %0d entries checked",
                 mismatches, other_errors, pop_count);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
